// File: rtl/video_pkg.sv
package video_pkg;

  // VGA raster coordinates, wide enough for the 800 clock line and 525 line frame
  typedef logic [9:0] hpos_t;
  typedef logic [9:0] vpos_t;

  // One pixel colour, packed as BBGGRR with blue in the top two bits
  typedef logic [5:0] rgb_t;

  // Horizontal timing in pixel clocks
  // The visible part of each line comes first, then front porch, sync and back porch
  localparam hpos_t H_VIEW  = 10'd640;
  localparam hpos_t H_TOTAL = 10'd800;

  // The horizontal sync pulse covers [H_SYNC_START, H_SYNC_END)
  localparam hpos_t H_SYNC_START = 10'd656;
  localparam hpos_t H_SYNC_END   = 10'd752;

  // Vertical timing in lines
  localparam vpos_t V_VIEW  = 10'd480;
  localparam vpos_t V_TOTAL = 10'd525;

  // The vertical sync pulse covers [V_SYNC_START, V_SYNC_END)
  localparam vpos_t V_SYNC_START = 10'd490;
  localparam vpos_t V_SYNC_END   = 10'd492;

  // Centre column of the visible line
  // Wall spans are drawn symmetrically about it, and it also splits floor from sky
  localparam hpos_t H_HALF = 10'd320;

endpackage

// File: rtl/texture_pkg.sv
package texture_pkg;

  // Number of texels in one vertical wall slice of a texture
  localparam int unsigned TEXEL_COUNT = 64;

  // Quad output fast read, the flash answers on all four io lines
  localparam logic [7:0] TSPI_CMD = 8'h6B;

  // Lengths of the stream fields, all counted in flash clocks
  localparam int unsigned TSPI_CMD_LEN      = 8;
  localparam int unsigned TSPI_ADDR_LEN     = 24;
  localparam int unsigned TSPI_DUMMY_LEN    = 8;
  localparam int unsigned TSPI_PREAMBLE_LEN = TSPI_CMD_LEN + TSPI_ADDR_LEN + TSPI_DUMMY_LEN;

  // Each texel is one byte in flash, read back as two nibbles
  localparam int unsigned TSPI_READ_LEN   = 2 * TEXEL_COUNT;
  localparam int unsigned TSPI_STREAM_LEN = TSPI_PREAMBLE_LEN + TSPI_READ_LEN;

  // The stream starts so that the first nibble arrives right as the visible line ends
  localparam int unsigned TSPI_HPOS_START = video_pkg::H_VIEW - TSPI_PREAMBLE_LEN;

  // Wall identifier, where zero means the ray hit nothing on this row
  typedef logic [1:0] wall_id_t;

  // Texture column and row inside one 64x64 texture
  typedef logic [5:0] texu_t;
  typedef logic [5:0] texv_t;

  // Half the wall height in pixels, may exceed half the screen width
  typedef logic [8:0] size_t;

  // Texture rows advanced per pixel, unsigned with 6 integer and 10 fraction bits
  typedef logic [15:0] step_t;

  // Byte address in the texture flash
  typedef logic [23:0] tex_addr_t;

  // A whole slice of texels, texel 0 at index 0, each in BBGGRR order
  typedef logic [TEXEL_COUNT-1:0][5:0] texel_line_t;

  // Which field of the QSPI stream the current clock belongs to
  typedef enum logic [2:0] {
    TSPI_IDLE,
    TSPI_SEND_CMD,
    TSPI_SEND_ADDR,
    TSPI_DUMMY,
    TSPI_READ
  } tspi_phase_t;

endpackage

// File: rtl/slice_if.sv
`timescale 1ns/1ps

// One wall-slice descriptor as seen by a single pipeline stage
interface slice_if import texture_pkg::*; ();

  // Zero here tells the consumers that this row has no wall at all
  wall_id_t wall;
  // Selects the darker or lighter face texture of the wall
  logic     side;
  texu_t    texu;
  size_t    size;
  step_t    step;

  // The stage register owner drives all fields
  modport src (
    output wall, side, texu, size, step
  );

  // Consumers only read the descriptor
  modport dst (
    input wall, side, texu, size, step
  );

endinterface

// File: rtl/scan_timing.sv
`timescale 1ns/1ps

module scan_timing
  import video_pkg::*;
(
  input  logic  clk,
  input  logic  reset,
  output hpos_t o_hpos,
  output vpos_t o_vpos,
  output logic  o_hmax,
  output logic  o_hsync_n,
  output logic  o_vsync_n,
  output logic  o_hblank,
  output logic  o_vblank,
  output logic  o_visible
);

  hpos_t h_next;
  vpos_t v_next;

  // Position of the following clock, all flags below are decoded from it
  // so that they come out of flops aligned with the counters
  always_comb begin
    h_next = (o_hpos == H_TOTAL - 1) ? '0 : o_hpos + 1'b1;
    v_next = o_vpos;
    if (o_hpos == H_TOTAL - 1) begin
      v_next = (o_vpos == V_TOTAL - 1) ? '0 : o_vpos + 1'b1;
    end
  end

  always_ff @(posedge clk) begin
    if (!reset) begin
      o_hpos    <= '0;
      o_vpos    <= '0;
      o_hmax    <= 1'b0;
      // Syncs are active low, so idle high
      o_hsync_n <= 1'b1;
      o_vsync_n <= 1'b1;
      o_hblank  <= 1'b0;
      o_vblank  <= 1'b0;
      // Position 0,0 is the first visible pixel
      o_visible <= 1'b1;
    end else begin
      o_hpos    <= h_next;
      o_vpos    <= v_next;
      o_hmax    <= (h_next == H_TOTAL - 1);
      o_hsync_n <= !(h_next >= H_SYNC_START && h_next < H_SYNC_END);
      o_vsync_n <= !(v_next >= V_SYNC_START && v_next < V_SYNC_END);
      o_hblank  <= (h_next >= H_VIEW);
      o_vblank  <= (v_next >= V_VIEW);
      o_visible <= (h_next < H_VIEW) && (v_next < V_VIEW);
    end
  end

endmodule

// File: rtl/slice_queue.sv
`timescale 1ns/1ps

module slice_queue
  import video_pkg::*;
  import texture_pkg::*;
(
  input  logic     clk,
  input  logic     reset,
  input  hpos_t    i_hpos,
  input  logic     i_slice_req,
  input  wall_id_t i_slice_wall,
  input  logic     i_slice_side,
  input  texu_t    i_slice_texu,
  input  size_t    i_slice_size,
  input  step_t    i_slice_step,
  output logic     o_slice_ack,
  slice_if.src     fetch_slice,
  slice_if.src     show_slice
);

  // Descriptor waiting for its row's fetch window
  logic     pend_full;
  wall_id_t pend_wall;
  logic     pend_side;
  texu_t    pend_texu;
  size_t    pend_size;
  step_t    pend_step;

  logic take;
  logic promote;
  logic advance;

  // A new request is only taken with ack low and the pending slot free
  // While the slot is full the tracer simply keeps req high and waits
  assign take = i_slice_req && !o_slice_ack && !pend_full;

  // Promote one clock ahead of the stream so the address is settled at its start
  assign promote = (i_hpos == TSPI_HPOS_START - 1);
  // The fetched texels become the visible row after the end of line
  assign advance = (i_hpos == H_TOTAL - 1);

  always_ff @(posedge clk) begin
    if (!reset) begin
      o_slice_ack      <= 1'b0;
      pend_full        <= 1'b0;
      fetch_slice.wall <= '0;
      show_slice.wall  <= '0;
    end else begin
      // Ack holds until the tracer drops req, completing the four phases
      if (take) begin
        o_slice_ack <= 1'b1;
      end else if (!i_slice_req) begin
        o_slice_ack <= 1'b0;
      end
      if (promote) begin
        pend_full <= 1'b0;
      end
      // Taking in the promote clock refills the slot that was already empty
      if (take) begin
        pend_full <= 1'b1;
      end
      // An empty slot turns into a row without a wall
      if (promote) begin
        fetch_slice.wall <= pend_full ? pend_wall : '0;
      end
      if (advance) begin
        show_slice.wall <= fetch_slice.wall;
      end
    end
  end

  // Descriptor payload follows the same strobes
  always_ff @(posedge clk) begin
    if (take) begin
      pend_wall <= i_slice_wall;
      pend_side <= i_slice_side;
      pend_texu <= i_slice_texu;
      pend_size <= i_slice_size;
      pend_step <= i_slice_step;
    end
    if (promote) begin
      fetch_slice.side <= pend_side;
      fetch_slice.texu <= pend_texu;
      fetch_slice.size <= pend_size;
      fetch_slice.step <= pend_step;
    end
    if (advance) begin
      show_slice.side <= fetch_slice.side;
      show_slice.texu <= fetch_slice.texu;
      show_slice.size <= fetch_slice.size;
      show_slice.step <= fetch_slice.step;
    end
  end

endmodule

// File: rtl/texture_fetch.sv
`timescale 1ns/1ps

module texture_fetch
  import video_pkg::*;
  import texture_pkg::*;
(
  input  logic        clk,
  input  logic        reset,
  input  hpos_t       i_hpos,
  slice_if.dst        fetch_slice,
  output logic        o_tex_csb,
  output logic        o_tex_sclk,
  output logic        o_tex_out0,
  output logic        o_tex_oeb0,
  input  logic [3:0]  i_tex_in,
  output texel_line_t o_texels
);

  // Stream position, wraps far outside the stream for the rest of the line
  hpos_t       stream_state;
  tspi_phase_t phase;
  wall_id_t    wall_index;
  tex_addr_t   slice_addr;

  // One bit plane per colour bit, filled one texel per pair of nibbles
  logic [TEXEL_COUNT-1:0] r0, r1, g0, g1, b0, b1;
  texel_line_t            captured;

  function automatic tspi_phase_t phase_of(input hpos_t state);
    if (state < TSPI_CMD_LEN) begin
      return TSPI_SEND_CMD;
    end else if (state < TSPI_CMD_LEN + TSPI_ADDR_LEN) begin
      return TSPI_SEND_ADDR;
    end else if (state < TSPI_PREAMBLE_LEN) begin
      return TSPI_DUMMY;
    end else if (state < TSPI_STREAM_LEN) begin
      return TSPI_READ;
    end
    return TSPI_IDLE;
  endfunction

  assign stream_state = hpos_t'(i_hpos - TSPI_HPOS_START);

  // Decoded one clock early from the next position so it lines up with i_hpos
  always_ff @(posedge clk) begin
    if (!reset) begin
      phase <= TSPI_IDLE;
    end else begin
      phase <= phase_of(stream_state + 10'd1);
    end
  end

  // Texture layout in flash is 2 bits wall, 1 bit side, 6 bits column, 6 bits texel
  assign wall_index = fetch_slice.wall - 2'd1;
  assign slice_addr = {9'd0, wall_index, fetch_slice.side, fetch_slice.texu, 6'd0};

  // Flash runs at the full pixel rate, io0 changes on clk rise and is
  // sampled by the flash half a clock later on its own rising edge
  assign o_tex_sclk = ~clk;
  assign o_tex_csb  = (phase == TSPI_IDLE);
  // io0 turns around at the start of the dummy clocks and stays an output otherwise
  assign o_tex_oeb0 = (phase == TSPI_DUMMY) || (phase == TSPI_READ);

  always_comb begin
    case (phase)
      // MSB first for both the command and the address
      TSPI_SEND_CMD:  o_tex_out0 = TSPI_CMD[3'd7 - stream_state[2:0]];
      TSPI_SEND_ADDR: o_tex_out0 = slice_addr[5'd31 - stream_state[4:0]];
      default:        o_tex_out0 = 1'b0;
    endcase
  end

  // Sample on the rising flash clock, the flash updates io on its falling edge
  // io3 carries no colour data and is left unsampled
  always_ff @(negedge clk) begin
    if (phase == TSPI_READ) begin
      if (!stream_state[0]) begin
        // First nibble of a byte holds the low colour bits
        r0 <= {i_tex_in[0], r0[TEXEL_COUNT-1:1]};
        g0 <= {i_tex_in[1], g0[TEXEL_COUNT-1:1]};
        b0 <= {i_tex_in[2], b0[TEXEL_COUNT-1:1]};
      end else begin
        r1 <= {i_tex_in[0], r1[TEXEL_COUNT-1:1]};
        g1 <= {i_tex_in[1], g1[TEXEL_COUNT-1:1]};
        b1 <= {i_tex_in[2], b1[TEXEL_COUNT-1:1]};
      end
    end
  end

  // Regroup the planes into BBGGRR texels
  always_comb begin
    for (int i = 0; i < TEXEL_COUNT; i++) begin
      captured[i] = {b1[i], b0[i], g1[i], g0[i], r1[i], r0[i]};
    end
  end

  // Freeze the line for the whole next row while the planes refill
  always_ff @(posedge clk) begin
    if (i_hpos == H_TOTAL - 1) begin
      o_texels <= captured;
    end
  end

endmodule

// File: rtl/wall_span.sv
`timescale 1ns/1ps

module wall_span
  import video_pkg::*;
  import texture_pkg::*;
(
  input  logic  clk,
  input  logic  reset,
  input  hpos_t i_hpos,
  input  logic  i_hmax,
  slice_if.dst  show_slice,
  output logic  o_wall_en,
  output texv_t o_texv
);

  // Signed so that tall walls can start left of column 0 and end past the line
  logic signed [10:0] col;
  logic signed [10:0] span_lo;
  logic signed [10:0] span_hi;

  // Texture row in 7.10 fixed point
  // Bit 16 set means the row has run past the bottom texel
  logic [16:0] texv_acc;

  assign col     = $signed({1'b0, i_hpos});
  assign span_lo = $signed({1'b0, H_HALF}) - $signed({2'b00, show_slice.size});
  assign span_hi = $signed({1'b0, H_HALF}) + $signed({2'b00, show_slice.size});

  // Half-open span centred on the screen
  assign o_wall_en = (show_slice.wall != '0) && (col >= span_lo) && (col < span_hi);

  // Starts at zero on the first wall pixel of each row
  always_ff @(posedge clk) begin
    if (!reset) begin
      texv_acc <= '0;
    end else if (i_hmax) begin
      texv_acc <= '0;
    end else if (o_wall_en && !texv_acc[16]) begin
      // Stop once saturated so the sum cannot wrap back into range
      texv_acc <= texv_acc + {1'b0, show_slice.step};
    end
  end

  // Clamp to the last texel row instead of wrapping
  assign o_texv = texv_acc[16] ? '1 : texv_acc[15:10];

endmodule

// File: rtl/pixel_mux.sv
`timescale 1ns/1ps

module pixel_mux
  import video_pkg::*;
  import texture_pkg::*;
(
  input  logic        i_visible,
  input  hpos_t       i_hpos,
  input  logic        i_wall_en,
  input  texv_t       i_texv,
  input  texel_line_t i_texels,
  input  rgb_t        i_sky,
  input  rgb_t        i_floor,
  output rgb_t        o_rgb
);

  // Pure decode of registered inputs, so the colour matches the current position
  always_comb begin
    if (!i_visible) begin
      // Blanking must stay black for the monitor's level reference
      o_rgb = '0;
    end else if (i_wall_en) begin
      o_rgb = i_texels[i_texv];
    end else if (i_hpos < H_HALF) begin
      // The rendered view is turned sideways, left half shows floor
      o_rgb = i_floor;
    end else begin
      o_rgb = i_sky;
    end
  end

endmodule

// File: rtl/raycast_row.sv
`timescale 1ns/1ps

module raycast_row
  import video_pkg::*;
  import texture_pkg::*;
(
  input  logic       clk,
  input  logic       reset,
  // Descriptor port from the wall tracer, four-phase req/ack
  input  logic       i_slice_req,
  input  wall_id_t   i_slice_wall,
  input  logic       i_slice_side,
  input  texu_t      i_slice_texu,
  input  size_t      i_slice_size,
  input  step_t      i_slice_step,
  output logic       o_slice_ack,
  // Background colours
  input  rgb_t       i_sky,
  input  rgb_t       i_floor,
  // Texture flash, io0 shared between output and input
  output logic       o_tex_csb,
  output logic       o_tex_sclk,
  output logic       o_tex_out0,
  output logic       o_tex_oeb0,
  input  logic [3:0] i_tex_in,
  // VGA side
  output logic       o_hsync_n,
  output logic       o_vsync_n,
  output logic       o_hblank,
  output logic       o_vblank,
  output hpos_t      o_hpos,
  output vpos_t      o_vpos,
  output rgb_t       o_rgb
);

  logic        hmax;
  logic        visible;
  logic        wall_en;
  texv_t       texv;
  texel_line_t texels;

  // Descriptor being fetched now and descriptor being drawn now
  slice_if fetch_slice ();
  slice_if show_slice ();

  scan_timing u_scan_timing (
    .clk       (clk),
    .reset     (reset),
    .o_hpos    (o_hpos),
    .o_vpos    (o_vpos),
    .o_hmax    (hmax),
    .o_hsync_n (o_hsync_n),
    .o_vsync_n (o_vsync_n),
    .o_hblank  (o_hblank),
    .o_vblank  (o_vblank),
    .o_visible (visible)
  );

  slice_queue u_slice_queue (
    .clk          (clk),
    .reset        (reset),
    .i_hpos       (o_hpos),
    .i_slice_req  (i_slice_req),
    .i_slice_wall (i_slice_wall),
    .i_slice_side (i_slice_side),
    .i_slice_texu (i_slice_texu),
    .i_slice_size (i_slice_size),
    .i_slice_step (i_slice_step),
    .o_slice_ack  (o_slice_ack),
    .fetch_slice  (fetch_slice.src),
    .show_slice   (show_slice.src)
  );

  texture_fetch u_texture_fetch (
    .clk         (clk),
    .reset       (reset),
    .i_hpos      (o_hpos),
    .fetch_slice (fetch_slice.dst),
    .o_tex_csb   (o_tex_csb),
    .o_tex_sclk  (o_tex_sclk),
    .o_tex_out0  (o_tex_out0),
    .o_tex_oeb0  (o_tex_oeb0),
    .i_tex_in    (i_tex_in),
    .o_texels    (texels)
  );

  wall_span u_wall_span (
    .clk        (clk),
    .reset      (reset),
    .i_hpos     (o_hpos),
    .i_hmax     (hmax),
    .show_slice (show_slice.dst),
    .o_wall_en  (wall_en),
    .o_texv     (texv)
  );

  pixel_mux u_pixel_mux (
    .i_visible (visible),
    .i_hpos    (o_hpos),
    .i_wall_en (wall_en),
    .i_texv    (texv),
    .i_texels  (texels),
    .i_sky     (i_sky),
    .i_floor   (i_floor),
    .o_rgb     (o_rgb)
  );

endmodule

// File: sim/raycast_row_chk.sv
`timescale 1ns/1ps

// Port-level protocol checks, bound into every raycast_row instance
module raycast_row_chk
  import video_pkg::*;
  import texture_pkg::*;
(
  input logic  clk,
  input logic  reset,
  input hpos_t i_hpos,
  input logic  i_tex_csb,
  input logic  i_tex_oeb0,
  input logic  i_slice_req,
  input logic  i_slice_ack,
  input rgb_t  i_rgb,
  input logic  i_hblank,
  input logic  i_vblank
);

  // Number of failed assertions so far, the testbench watches it
  int unsigned fail_count = 0;

  // The flash is selected only inside the stream window of a line
  csb_window: assert property (@(posedge clk) disable iff (!reset)
    !i_tex_csb |-> (i_hpos >= TSPI_HPOS_START && i_hpos < TSPI_HPOS_START + TSPI_STREAM_LEN))
  else begin
    $error("flash selected outside the stream window at hpos %0d", i_hpos);
    fail_count++;
  end

  // io0 is released for the flash only while it is selected
  oeb_in_frame: assert property (@(posedge clk) disable iff (!reset)
    i_tex_oeb0 |-> !i_tex_csb)
  else begin
    $error("io0 turned around while the flash is deselected");
    fail_count++;
  end

  // An acknowledge never appears without a pending request
  ack_after_req: assert property (@(posedge clk) disable iff (!reset)
    $rose(i_slice_ack) |-> i_slice_req)
  else begin
    $error("ack rose while req was low");
    fail_count++;
  end

  // Blanking intervals carry black
  black_in_blank: assert property (@(posedge clk) disable iff (!reset)
    (i_hblank || i_vblank) |-> (i_rgb == '0))
  else begin
    $error("colour %0h driven during blanking", i_rgb);
    fail_count++;
  end

endmodule

// File: sim/tb_raycast_row.sv
`timescale 1ns/1ps

module tb_raycast_row
  import video_pkg::*;
  import texture_pkg::*;
();

  localparam int RESET_CYCLES   = 16;
  // Two whole frames plus the reset time
  localparam int TIMEOUT_CYCLES = 2 * int'(V_TOTAL) * int'(H_TOTAL) + RESET_CYCLES;
  localparam logic [31:0] SEED  = 32'h2982_5e88;

  // One descriptor as the tracer hands it over
  typedef struct packed {
    wall_id_t wall;
    logic     side;
    texu_t    texu;
    size_t    size;
    step_t    step;
  } slice_t;

  logic        clk = 1'b0;
  logic        reset;
  logic        slice_req;
  wall_id_t    slice_wall;
  logic        slice_side;
  texu_t       slice_texu;
  size_t       slice_size;
  step_t       slice_step;
  logic        slice_ack;
  rgb_t        sky;
  rgb_t        floor_col;
  logic        tex_csb;
  logic        tex_sclk;
  logic        tex_out0;
  logic        tex_oeb0;
  logic [3:0]  tex_in;
  logic        hsync_n;
  logic        vsync_n;
  logic        hblank;
  logic        vblank;
  hpos_t       hpos;
  vpos_t       vpos;
  rgb_t        rgb;

  // Expected raster position, absolute line count and handshake history
  int          exp_h = 0;
  int          exp_v = 0;
  int          line_no = 0;
  int          prev_h = 0;
  int          prev_line = 0;
  logic        prev_req = 1'b0;
  logic        prev_ack = 1'b0;
  int          req_rises = 0;
  int          ack_rises = 0;
  int          req_wait = 0;
  int          wall_rows = 0;
  int          cycle_count = 0;
  // Accepted descriptors, indexed by the line that must show them
  slice_t      shown[int];

  // Flash model state, counted in rising flash clocks
  int          flash_bits = 0;
  logic [7:0]  flash_cmd;
  tex_addr_t   flash_addr;

  always #20 clk = ~clk;

  raycast_row i_dut (
    .clk          (clk),
    .reset        (reset),
    .i_slice_req  (slice_req),
    .i_slice_wall (slice_wall),
    .i_slice_side (slice_side),
    .i_slice_texu (slice_texu),
    .i_slice_size (slice_size),
    .i_slice_step (slice_step),
    .o_slice_ack  (slice_ack),
    .i_sky        (sky),
    .i_floor      (floor_col),
    .o_tex_csb    (tex_csb),
    .o_tex_sclk   (tex_sclk),
    .o_tex_out0   (tex_out0),
    .o_tex_oeb0   (tex_oeb0),
    .i_tex_in     (tex_in),
    .o_hsync_n    (hsync_n),
    .o_vsync_n    (vsync_n),
    .o_hblank     (hblank),
    .o_vblank     (vblank),
    .o_hpos       (hpos),
    .o_vpos       (vpos),
    .o_rgb        (rgb)
  );

  bind raycast_row raycast_row_chk u_chk (
    .clk         (clk),
    .reset       (reset),
    .i_hpos      (o_hpos),
    .i_tex_csb   (o_tex_csb),
    .i_tex_oeb0  (o_tex_oeb0),
    .i_slice_req (i_slice_req),
    .i_slice_ack (o_slice_ack),
    .i_rgb       (o_rgb),
    .i_hblank    (o_hblank),
    .i_vblank    (o_vblank)
  );

  task automatic stop_with_failure(input string reason);
    $display("Failure: %s", reason);
    $display("RESULT: FAIL");
    $fatal(1, "%s", reason);
  endtask

  task automatic check_value(input string name, input logic [31:0] expected,
                             input logic [31:0] actual);
    if (actual !== expected) begin
      $display("** Error [%s]: expected %0h, actual %0h at line %0d hpos %0d",
               name, expected, actual, line_no, exp_h);
      $display("RESULT: FAIL");
      $fatal(1, "check %s failed", name);
    end
  endtask

  // Flash content, a texel colour for every byte address
  function automatic rgb_t flash_byte(input tex_addr_t addr);
    logic [31:0] mixed;
    mixed = {8'd0, addr} * 32'd37 + 32'd11;
    return mixed[5:0];
  endfunction

  // Texture base: wall minus one, side, column, then 64 texels per column
  function automatic tex_addr_t slice_address(input slice_t s);
    wall_id_t wall_index;
    wall_index = s.wall - 2'd1;
    return {9'd0, wall_index, s.side, s.texu, 6'd0};
  endfunction

  function automatic rgb_t expected_pixel(input slice_t s, input int h, input int v,
                                          input rgb_t sky_col, input rgb_t floor_c);
    int span_lo;
    int span_hi;
    int k;
    int row;
    span_lo = int'(H_HALF) - int'(s.size);
    span_hi = int'(H_HALF) + int'(s.size);
    if (h >= int'(H_VIEW) || v >= int'(V_VIEW)) begin
      return '0;
    end
    if (s.wall != '0 && h >= span_lo && h < span_hi) begin
      // Wall pixels are counted from the first one on screen
      k = (span_lo < 0) ? h : h - span_lo;
      row = (k * int'(s.step)) / 1024;
      if (row > 63) begin
        row = 63;
      end
      return flash_byte(slice_address(s) + tex_addr_t'(row));
    end
    if (h < int'(H_HALF)) begin
      return floor_c;
    end
    return sky_col;
  endfunction

  // One four-phase handshake per row, starting at a random column
  task automatic drive_descriptors();
    int start_col;
    forever begin
      start_col = $urandom_range(0, 780);
      @(posedge clk);
      while (int'(hpos) != start_col) begin
        @(posedge clk);
      end
      slice_req  <= 1'b1;
      slice_wall <= wall_id_t'($urandom_range(0, 3));
      slice_side <= 1'($urandom_range(0, 1));
      slice_texu <= texu_t'($urandom_range(0, 63));
      // Sizes past 320 make the wall cover the whole line
      slice_size <= size_t'($urandom_range(0, 400));
      slice_step <= step_t'($urandom_range(0, 4095));
      sky        <= rgb_t'($urandom);
      floor_col  <= rgb_t'($urandom);
      @(posedge clk);
      while (!slice_ack) begin
        @(posedge clk);
      end
      slice_req <= 1'b0;
      @(posedge clk);
      while (slice_ack) begin
        @(posedge clk);
      end
    end
  endtask

  // Flash model, header bits are taken on the rising flash clock
  always @(posedge tex_sclk) begin
    if (tex_csb !== 1'b0) begin
      flash_bits = 0;
    end else begin
      // The DUT drives io0 for the command and address and releases it after
      check_value("io0 direction", flash_bits >= int'(TSPI_CMD_LEN + TSPI_ADDR_LEN),
                  tex_oeb0);
      if (flash_bits < int'(TSPI_CMD_LEN)) begin
        flash_cmd = {flash_cmd[6:0], tex_out0};
      end else if (flash_bits < int'(TSPI_CMD_LEN + TSPI_ADDR_LEN)) begin
        flash_addr = {flash_addr[22:0], tex_out0};
      end
      flash_bits++;
      // The line being fetched is shown on the next line
      if (flash_bits == int'(TSPI_CMD_LEN + TSPI_ADDR_LEN)) begin
        check_value("flash command", TSPI_CMD, flash_cmd);
        if (shown.exists(line_no + 1)) begin
          check_value("flash address", slice_address(shown[line_no + 1]), flash_addr);
        end
      end
    end
  end

  // Read data goes out on the falling flash clock, one nibble per clock
  always @(negedge tex_sclk) begin
    int   n;
    rgb_t texel;
    if (flash_bits >= int'(TSPI_PREAMBLE_LEN) && flash_bits < int'(TSPI_STREAM_LEN)) begin
      n = flash_bits - int'(TSPI_PREAMBLE_LEN);
      texel = flash_byte(flash_addr + tex_addr_t'(n / 2));
      // io0, io1 and io2 carry red, green and blue, low bits in the first nibble
      if (n % 2 == 0) begin
        tex_in <= {1'b0, texel[4], texel[2], texel[0]};
      end else begin
        tex_in <= {1'b0, texel[5], texel[3], texel[1]};
      end
    end
  end

  // Compares every output with the reference on each clock after reset
  always @(posedge clk) begin
    slice_t cur;
    slice_t taken;
    int     show_line;
    if (reset) begin
      check_value("hpos", exp_h, hpos);
      check_value("vpos", exp_v, vpos);
      check_value("hsync", !(exp_h >= int'(H_SYNC_START) && exp_h < int'(H_SYNC_END)), hsync_n);
      check_value("vsync", !(exp_v >= int'(V_SYNC_START) && exp_v < int'(V_SYNC_END)), vsync_n);
      check_value("hblank", exp_h >= int'(H_VIEW), hblank);
      check_value("vblank", exp_v >= int'(V_VIEW), vblank);
      check_value("bound assertions", 0, i_dut.u_chk.fail_count);
      if (slice_req && !prev_req) begin
        req_rises++;
      end
      // A waiting request is served at the latest one promote later
      if (slice_req && !slice_ack) begin
        req_wait++;
        if (req_wait > int'(H_TOTAL) + 2) begin
          stop_with_failure("a request waited more than a line without an ack");
        end
      end else begin
        req_wait = 0;
      end
      // Ack rising now means the descriptor was taken on the previous clock
      if (slice_ack && !prev_ack) begin
        check_value("ack per request", req_rises, ack_rises + 1);
        ack_rises++;
        taken = {slice_wall, slice_side, slice_texu, slice_size, slice_step};
        show_line = prev_line + ((prev_h < int'(TSPI_HPOS_START) - 1) ? 1 : 2);
        if (shown.exists(show_line)) begin
          stop_with_failure("two descriptors were accepted for the same row");
        end
        shown[show_line] = taken;
      end
      cur = shown.exists(line_no) ? shown[line_no] : '0;
      check_value("pixel", expected_pixel(cur, exp_h, exp_v, sky, floor_col), rgb);
      if (exp_h == 0 && exp_v < int'(V_VIEW) && cur.wall != '0) begin
        wall_rows++;
      end
      prev_req  = slice_req;
      prev_ack  = slice_ack;
      prev_h    = exp_h;
      prev_line = line_no;
      if (exp_h == int'(H_TOTAL) - 1) begin
        exp_h = 0;
        line_no++;
        exp_v = (exp_v == int'(V_TOTAL) - 1) ? 0 : exp_v + 1;
      end else begin
        exp_h++;
      end
    end
  end

  always @(posedge clk) begin
    cycle_count++;
    if (cycle_count >= TIMEOUT_CYCLES) begin
      stop_with_failure("the frame did not complete before the cycle limit");
    end
  end

  initial begin
    void'($urandom(SEED));
    reset      = 1'b0;
    slice_req  = 1'b0;
    slice_wall = '0;
    slice_side = 1'b0;
    slice_texu = '0;
    slice_size = '0;
    slice_step = '0;
    sky        = 6'h30;
    floor_col  = 6'h05;
    tex_in     = 4'h0;
    repeat (RESET_CYCLES) @(posedge clk);
    reset <= 1'b1;
    fork
      drive_descriptors();
    join_none
    // One whole frame, plus the first line of the next
    while (line_no < int'(V_TOTAL) + 1) begin
      @(posedge clk);
    end
    if (i_dut.u_chk.fail_count != 0 || wall_rows == 0) begin
      stop_with_failure("no wall was drawn or an assertion failed");
    end else begin
      $display("Frame done with %0d descriptors and %0d textured rows", ack_rises, wall_rows);
      $display("RESULT: PASS");
      $finish;
    end
  end

endmodule

// File: filelist.f
rtl/video_pkg.sv
rtl/texture_pkg.sv
rtl/slice_if.sv
rtl/scan_timing.sv
rtl/slice_queue.sv
rtl/texture_fetch.sv
rtl/wall_span.sv
rtl/pixel_mux.sv
rtl/raycast_row.sv
sim/raycast_row_chk.sv
sim/tb_raycast_row.sv

// File: Bender.yml
package:
  name: raycast_row

sources:
  - files:
      - rtl/video_pkg.sv
      - rtl/texture_pkg.sv
      - rtl/slice_if.sv
      - rtl/scan_timing.sv
      - rtl/slice_queue.sv
      - rtl/texture_fetch.sv
      - rtl/wall_span.sv
      - rtl/pixel_mux.sv
      - rtl/raycast_row.sv
  - target: simulation
    files:
      - sim/raycast_row_chk.sv
      - sim/tb_raycast_row.sv
